// File: logic/spmd_loader_pkg.sv
package spmd_loader_pkg;

  // array geometry.
  localparam int NUM_ROWS  = 2;
  localparam int NUM_COLS  = 3;
  localparam int NUM_TILES = NUM_ROWS * NUM_COLS;

  // program image, sized in bytes and loaded one 32-bit word at a time.
  localparam int MEM_SIZE    = 64;
  localparam int IMAGE_WORDS = MEM_SIZE / 4;

  // byte address of the word that each tile reads its own number from.
  localparam int TILE_ID_PTR = 8;

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;

  // y has one extra row for the off-array return edge.
  localparam int X_WIDTH = $clog2(NUM_COLS);
  localparam int Y_WIDTH = $clog2(NUM_ROWS + 1);

  localparam int WORD_IDX_WIDTH = $clog2(IMAGE_WORDS);
  localparam int TILE_IDX_WIDTH = $clog2(NUM_TILES);

  // network opcodes used by the loader.
  typedef enum logic [1:0] {
    OP_STORE    = 2'b01,
    OP_UNFREEZE = 2'b10
  } manycore_op_e;

  typedef enum logic [1:0] {
    ST_LOAD,
    ST_UNFREEZE,
    ST_DONE
  } loader_state_e;

  // where a response to the packet would be routed.
  typedef struct packed {
    logic [X_WIDTH-1:0] x_cord;
    logic [Y_WIDTH-1:0] y_cord;
  } return_cord_s;

  typedef struct packed {
    return_cord_s            return_pkt;
    logic [Y_WIDTH-1:0]      y_cord;
    logic [X_WIDTH-1:0]      x_cord;
    logic [DATA_WIDTH-1:0]   data;
    logic [ADDR_WIDTH-1:0]   addr;
    manycore_op_e            op;
    // byte mask for stores.
    logic [3:0]              op_ex;
  } manycore_packet_s;

endpackage

// File: logic/loader_fsm.sv
`timescale 1ns/1ps

module loader_fsm
  (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           step_i,
    input  logic                           word_last_i,
    input  logic                           tile_last_i,
    output spmd_loader_pkg::loader_state_e state_o
  );

  import spmd_loader_pkg::*;

  loader_state_e state_r;
  loader_state_e state_n;

  logic image_done;
  logic unfreeze_done;

  // the last word of the last tile is being taken.
  assign image_done = step_i & word_last_i & tile_last_i;

  // the last tile has been sent its unfreeze packet.
  assign unfreeze_done = step_i & tile_last_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      ST_LOAD:
      begin
        if (image_done)
        begin
          state_n = ST_UNFREEZE;
        end
      end
      ST_UNFREEZE:
      begin
        if (unfreeze_done)
        begin
          state_n = ST_DONE;
        end
      end
      ST_DONE:
      begin
        // stays here until the next reset.
        state_n = ST_DONE;
      end
      default:
      begin
        state_n = ST_LOAD;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= ST_LOAD;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  assign state_o = state_r;

endmodule

// File: logic/load_counter.sv
`timescale 1ns/1ps

module load_counter
  (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        step_i,
    input  spmd_loader_pkg::loader_state_e              state_i,
    output logic [spmd_loader_pkg::WORD_IDX_WIDTH-1:0]  word_idx_o,
    output logic [spmd_loader_pkg::TILE_IDX_WIDTH-1:0]  tile_idx_o,
    output logic                                        word_last_o,
    output logic                                        tile_last_o
  );

  import spmd_loader_pkg::*;

  logic [WORD_IDX_WIDTH-1:0] word_idx_r;
  logic [TILE_IDX_WIDTH-1:0] tile_idx_r;
  logic [WORD_IDX_WIDTH-1:0] word_idx_n;
  logic [TILE_IDX_WIDTH-1:0] tile_idx_n;
  logic [TILE_IDX_WIDTH-1:0] tile_idx_inc;

  logic word_last;
  logic tile_last;

  assign word_last = (word_idx_r == WORD_IDX_WIDTH'(IMAGE_WORDS - 1));
  assign tile_last = (tile_idx_r == TILE_IDX_WIDTH'(NUM_TILES - 1));

  // next tile in row-major order, wrapping after the last one.
  assign tile_idx_inc = tile_last ? '0 : tile_idx_r + 1'b1;

  always_comb
  begin
    word_idx_n = word_idx_r;
    tile_idx_n = tile_idx_r;
    if (step_i)
    begin
      case (state_i)
        ST_LOAD:
        begin
          // the tile moves on when its image wraps.
          word_idx_n = word_last ? '0 : word_idx_r + 1'b1;
          if (word_last)
          begin
            tile_idx_n = tile_idx_inc;
          end
        end
        ST_UNFREEZE:
        begin
          tile_idx_n = tile_idx_inc;
        end
        default:
        begin
          word_idx_n = word_idx_r;
          tile_idx_n = tile_idx_r;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      word_idx_r <= '0;
      tile_idx_r <= '0;
    end
    else
    begin
      word_idx_r <= word_idx_n;
      tile_idx_r <= tile_idx_n;
    end
  end

  assign word_idx_o  = word_idx_r;
  assign tile_idx_o  = tile_idx_r;
  assign word_last_o = word_last;
  assign tile_last_o = tile_last;

endmodule

// File: logic/packet_builder.sv
`timescale 1ns/1ps

module packet_builder
  (
    input  spmd_loader_pkg::loader_state_e              state_i,
    input  logic [spmd_loader_pkg::WORD_IDX_WIDTH-1:0]  word_idx_i,
    input  logic [spmd_loader_pkg::TILE_IDX_WIDTH-1:0]  tile_idx_i,
    input  logic [spmd_loader_pkg::DATA_WIDTH-1:0]      image_data_i,
    output spmd_loader_pkg::manycore_packet_s           pkt_o,
    output logic [spmd_loader_pkg::ADDR_WIDTH-1:0]      image_addr_o
  );

  import spmd_loader_pkg::*;

  logic [Y_WIDTH-1:0]    y_cord;
  logic [X_WIDTH-1:0]    x_cord;
  logic [ADDR_WIDTH-1:0] byte_addr;
  logic [DATA_WIDTH-1:0] load_data;
  logic                  storing;
  logic                  at_tile_id;

  assign storing = (state_i == ST_LOAD);

  // row-major split of the tile number.
  assign y_cord = Y_WIDTH'(tile_idx_i / NUM_COLS);
  assign x_cord = X_WIDTH'(tile_idx_i % NUM_COLS);

  // tiles are byte addressed, the image memory is word addressed.
  assign byte_addr    = ADDR_WIDTH'({word_idx_i, 2'b00});
  assign image_addr_o = ADDR_WIDTH'(word_idx_i);

  assign at_tile_id = (byte_addr == ADDR_WIDTH'(TILE_ID_PTR));

  // unfreeze packets carry no data.
  // each tile gets its own number patched into the image.
  always_comb
  begin
    if (!storing)
    begin
      load_data = '0;
    end
    else if (at_tile_id)
    begin
      load_data = DATA_WIDTH'(tile_idx_i);
    end
    else
    begin
      load_data = image_data_i;
    end
  end

  always_comb
  begin
    pkt_o.data   = load_data;
    pkt_o.addr   = byte_addr;
    pkt_o.x_cord = x_cord;
    pkt_o.y_cord = y_cord;
    if (storing)
    begin
      pkt_o.op    = OP_STORE;
      pkt_o.op_ex = 4'b1111;
    end
    else
    begin
      pkt_o.op    = OP_UNFREEZE;
      pkt_o.op_ex = 4'b0000;
    end
    // responses go to the collector just past the bottom row.
    pkt_o.return_pkt.x_cord = '0;
    pkt_o.return_pkt.y_cord = Y_WIDTH'(NUM_ROWS);
  end

endmodule

// File: logic/spmd_loader.sv
`timescale 1ns/1ps

module spmd_loader
  (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    ready_i,
    input  logic [spmd_loader_pkg::DATA_WIDTH-1:0]  image_data_i,
    output spmd_loader_pkg::manycore_packet_s       data_o,
    output logic                                    v_o,
    output logic                                    done_o,
    output logic [spmd_loader_pkg::ADDR_WIDTH-1:0]  image_addr_o
  );

  import spmd_loader_pkg::*;

  loader_state_e             state;
  logic [WORD_IDX_WIDTH-1:0] word_idx;
  logic [TILE_IDX_WIDTH-1:0] tile_idx;
  logic                      word_last;
  logic                      tile_last;
  logic                      step;

  // a packet is offered until the run is done.
  assign v_o = ~reset_i & (state != ST_DONE);

  // a packet is taken when offered and accepted in the same cycle.
  assign step = v_o & ready_i;

  assign done_o = (state == ST_DONE);

  loader_fsm u_fsm
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .step_i      (step),
    .word_last_i (word_last),
    .tile_last_i (tile_last),
    .state_o     (state)
  );

  load_counter u_counter
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .step_i      (step),
    .state_i     (state),
    .word_idx_o  (word_idx),
    .tile_idx_o  (tile_idx),
    .word_last_o (word_last),
    .tile_last_o (tile_last)
  );

  // packet and memory address follow the registered counters directly.
  packet_builder u_builder
  (
    .state_i      (state),
    .word_idx_i   (word_idx),
    .tile_idx_i   (tile_idx),
    .image_data_i (image_data_i),
    .pkt_o        (data_o),
    .image_addr_o (image_addr_o)
  );

endmodule

// File: tb/spmd_loader_asserts.sv
`timescale 1ns/1ps

module spmd_loader_asserts
  (
    input logic                                    clk_i,
    input logic                                    reset_i,
    input logic                                    ready_i,
    input spmd_loader_pkg::manycore_packet_s       data_o,
    input logic                                    v_o,
    input logic                                    done_o,
    input logic [spmd_loader_pkg::ADDR_WIDTH-1:0]  image_addr_o
  );

  import spmd_loader_pkg::*;

  int assert_errors = 0;

  // a packet that is offered but not taken stays on the bus.
  data_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !ready_i) |=> $stable(data_o))
    else
    begin
      assert_errors++;
      $error("data_o changed while the packet was stalled");
    end

  // once finished, the loader stays done and offers nothing.
  quiet_when_done_a: assert property (@(posedge clk_i) disable iff (reset_i)
    done_o |=> (done_o && !v_o))
    else
    begin
      assert_errors++;
      $error("done_o dropped or v_o rose after the run finished");
    end

  // each taken store moves the read to the next image word, wrapping at the end.
  addr_steps_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && ready_i && data_o.op == OP_STORE) |=>
      image_addr_o == ADDR_WIDTH'(($past(image_addr_o) + 1) % IMAGE_WORDS))
    else
    begin
      assert_errors++;
      $error("image_addr_o did not step to the next image word");
    end

endmodule

bind spmd_loader spmd_loader_asserts u_asserts
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ready_i      (ready_i),
    .data_o       (data_o),
    .v_o          (v_o),
    .done_o       (done_o),
    .image_addr_o (image_addr_o)
  );

// File: tb/spmd_loader_tb.sv
`timescale 1ns/1ps

module spmd_loader_tb;

  import spmd_loader_pkg::*;

  logic                  clk_i;
  logic                  reset_i;
  logic                  ready_i;
  logic [DATA_WIDTH-1:0] image_data_i;
  manycore_packet_s      data_o;
  logic                  v_o;
  logic                  done_o;
  logic [ADDR_WIDTH-1:0] image_addr_o;

  logic [DATA_WIDTH-1:0] image_mem [IMAGE_WORDS];
  logic [31:0]           lfsr_state;
  int                    step_count;
  int                    error_count;
  int                    cycle_count;
  int                    ready_phase;

  // snapshot of a stalled packet, compared one cycle later.
  logic                  held_valid;
  manycore_packet_s      held_pkt;
  logic [ADDR_WIDTH-1:0] held_addr;

  spmd_loader u_spmd_loader
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ready_i      (ready_i),
    .image_data_i (image_data_i),
    .data_o       (data_o),
    .v_o          (v_o),
    .done_o       (done_o),
    .image_addr_o (image_addr_o)
  );

  always #20 clk_i = ~clk_i;

  // image memory model, read in the same cycle.
  assign image_data_i = (image_addr_o < IMAGE_WORDS) ?
                        image_mem[image_addr_o[WORD_IDX_WIDTH-1:0]] :
                        {16'hdead, image_addr_o};

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], feedback};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // store steps first, tile by tile, then one unfreeze per tile.
  function automatic manycore_packet_s expected_packet(input int n,
      input logic [DATA_WIDTH-1:0] img [IMAGE_WORDS]);
    manycore_packet_s pkt;
    int tile;
    int word;
    if (n < NUM_TILES * IMAGE_WORDS)
    begin
      tile = n / IMAGE_WORDS;
      word = n % IMAGE_WORDS;
    end
    else
    begin
      tile = n - NUM_TILES * IMAGE_WORDS;
      word = 0;
    end
    pkt.return_pkt.x_cord = '0;
    pkt.return_pkt.y_cord = Y_WIDTH'(NUM_ROWS);
    pkt.y_cord = Y_WIDTH'(tile / NUM_COLS);
    pkt.x_cord = X_WIDTH'(tile % NUM_COLS);
    pkt.addr   = ADDR_WIDTH'(word * 4);
    if (n < NUM_TILES * IMAGE_WORDS)
    begin
      pkt.op    = OP_STORE;
      pkt.op_ex = 4'b1111;
      if (word * 4 == TILE_ID_PTR)
      begin
        pkt.data = DATA_WIDTH'(tile);
      end
      else
      begin
        pkt.data = img[word];
      end
    end
    else
    begin
      pkt.op    = OP_UNFREEZE;
      pkt.op_ex = 4'b0000;
      pkt.data  = '0;
    end
    return pkt;
  endfunction

  task automatic report_mismatch(input string test_name, input logic [63:0] expected,
      input logic [63:0] actual);
    error_count++;
    $display("CHECK FAILED %s: expected %h, actual %h (step %0d)",
             test_name, expected, actual, step_count);
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR: %s (step %0d)", what, step_count);
  endtask

  // ready_i is random, but high on every fourth cycle.
  always @(posedge clk_i)
  begin
    logic [31:0] rand_bits;
    #2;
    take_bits(1, rand_bits);
    ready_phase = ready_phase + 1;
    if (ready_phase % 4 == 0)
    begin
      ready_i = 1'b1;
    end
    else
    begin
      ready_i = rand_bits[0];
    end
  end

  // outputs are stable at the falling edge.
  always @(negedge clk_i)
  begin
    manycore_packet_s exp_pkt;
    string            test_name;
    if (reset_i)
    begin
      if (v_o !== 1'b0)
        report_error("v_o high during reset");
      if (done_o !== 1'b0)
        report_error("done_o high during reset");
      held_valid = 1'b0;
    end
    else
    begin
      if (held_valid && data_o !== held_pkt)
        report_mismatch("backpressure_data", held_pkt, data_o);
      if (held_valid && image_addr_o !== held_addr)
        report_mismatch("backpressure_addr", held_addr, image_addr_o);
      if (step_count == NUM_TILES * IMAGE_WORDS + NUM_TILES && done_o !== 1'b1)
        report_error("done_o not high after the last unfreeze packet");
      if (step_count < NUM_TILES * IMAGE_WORDS + NUM_TILES && done_o === 1'b1)
        report_error("done_o high before all packets were taken");
      if (v_o === 1'b1 && ready_i === 1'b1)
      begin
        if (step_count >= NUM_TILES * IMAGE_WORDS + NUM_TILES)
        begin
          report_error("packet taken after the last unfreeze packet");
        end
        else
        begin
          exp_pkt = expected_packet(step_count, image_mem);
          if (step_count >= NUM_TILES * IMAGE_WORDS)
            test_name = "unfreeze";
          else if ((step_count % IMAGE_WORDS) * 4 == TILE_ID_PTR)
            test_name = "tile_id";
          else
            test_name = "store";
          if (data_o !== exp_pkt)
            report_mismatch(test_name, exp_pkt, data_o);
          if (step_count < NUM_TILES * IMAGE_WORDS &&
              image_addr_o !== ADDR_WIDTH'(step_count % IMAGE_WORDS))
            report_mismatch("image_addr", step_count % IMAGE_WORDS, image_addr_o);
        end
        step_count++;
      end
      held_valid = (v_o === 1'b1) && (ready_i === 1'b0);
      held_pkt   = data_o;
      held_addr  = image_addr_o;
    end
  end

  initial
  begin
    logic [31:0] rand_word;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    ready_i     = 1'b0;
    lfsr_state  = 32'h7800_86d2;
    step_count  = 0;
    error_count = 0;
    cycle_count = 0;
    ready_phase = 0;
    held_valid  = 1'b0;
    for (int w = 0; w < IMAGE_WORDS; w++)
    begin
      take_bits(32, rand_word);
      image_mem[w] = rand_word;
    end
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // 102 steps at half readiness take about 204 cycles.
    while (done_o !== 1'b1 && cycle_count < 1000)
    begin
      @(negedge clk_i);
      cycle_count++;
    end
    if (cycle_count >= 1000)
    begin
      $display("timeout: done_o not seen after %0d cycles, %0d packets taken",
               cycle_count, step_count);
      $display("SIMULATION FAILED");
      $finish;
    end
    else
    begin
      // the loader has to stay quiet after finishing.
      repeat (4) @(negedge clk_i);
      if (v_o !== 1'b0)
        report_error("v_o high after done");
      if (done_o !== 1'b1)
        report_error("done_o dropped after the run finished");
      if (step_count != NUM_TILES * IMAGE_WORDS + NUM_TILES)
        report_mismatch("packet_count", NUM_TILES * IMAGE_WORDS + NUM_TILES, step_count);
      $display("errors: %0d, assertion errors: %0d, packets taken: %0d, cycles: %0d",
               error_count, u_spmd_loader.u_asserts.assert_errors, step_count,
               cycle_count);
      if (error_count == 0 && u_spmd_loader.u_asserts.assert_errors == 0)
      begin
        $display("SIMULATION PASSED");
      end
      else
      begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

// File: spmd_loader.f
logic/spmd_loader_pkg.sv
logic/loader_fsm.sv
logic/load_counter.sv
logic/packet_builder.sv
logic/spmd_loader.sv
tb/spmd_loader_asserts.sv
tb/spmd_loader_tb.sv
